//--- source/i2c_settings.svh
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// Seven-bit slave address on the I2C bus
`define I2C_DEVICE_ADDR 7'h42

// Register bank depth, a power of two
`define I2C_NUM_REGS 8

// Register index width
`define I2C_REG_AW 3

// APB word address width
`define I2C_APB_AW 8

// Byte width on both sides
`define I2C_DATA_W 8

`endif

//--- source/i2c_bus_pkg.sv
`default_nettype none

`include "i2c_settings.svh"

package i2c_bus_pkg;

	//////////////////////////////////////////////////
	// Sampled bus events
	//////////////////////////////////////////////////

	// One-cycle pulses, plus the synced SDA level
	typedef struct packed {
		logic scl_rise;
		logic scl_fall;
		logic start;
		logic stop;
		logic sda;
	} bus_event_t;

	//////////////////////////////////////////////////
	// Serializer commands
	//////////////////////////////////////////////////

	// ack_go starts an ACK bit, load_go a data byte
	typedef struct packed {
		logic ack_go;
		logic load_go;
		logic [`I2C_DATA_W-1:0] data;
	} ser_cmd_t;

endpackage

`default_nettype wire

//--- source/reg_access_pkg.sv
`default_nettype none

`include "i2c_settings.svh"

package reg_access_pkg;

	// APB request from the host side
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`I2C_APB_AW-1:0] paddr;
		logic [`I2C_DATA_W-1:0] pwdata;
	} apb_req_t;

	// APB response, no wait states
	typedef struct packed {
		logic [`I2C_DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// Controller access into the bank
	typedef struct packed {
		logic wr;
		logic [`I2C_REG_AW-1:0] addr;
		logic [`I2C_DATA_W-1:0] wdata;
	} reg_port_t;

endpackage

`default_nettype wire

//--- source/i2c_line_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_line_monitor
	import i2c_bus_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input logic scl,
	input logic sda,
	output bus_event_t bus_ev
);

	// Two-flop synchronizers
	logic scl_s1;
	logic scl_s2;
	logic sda_s1;
	logic sda_s2;
	// Previous synced levels
	logic scl_q;
	logic sda_q;

	//////////////////////////////////////////////////
	// Sync, edge detect, START and STOP decode
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			// Idle bus is high on both lines
			scl_s1 <= 1'b1;
			scl_s2 <= 1'b1;
			sda_s1 <= 1'b1;
			sda_s2 <= 1'b1;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			bus_ev <= '0;
			bus_ev.sda <= 1'b1;
		end
		else
		begin
			scl_s1 <= scl;
			scl_s2 <= scl_s1;
			sda_s1 <= sda;
			sda_s2 <= sda_s1;
			scl_q <= scl_s2;
			sda_q <= sda_s2;
			// SCL edges
			bus_ev.scl_rise <= scl_s2 & ~scl_q;
			bus_ev.scl_fall <= ~scl_s2 & scl_q;
			// SDA falls while SCL stays high
			bus_ev.start <= scl_s2 & scl_q & sda_q & ~sda_s2;
			// SDA rises while SCL stays high
			bus_ev.stop <= scl_s2 & scl_q & ~sda_q & sda_s2;
			// Level aligned with the pulses
			bus_ev.sda <= sda_s2;
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_byte_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_receiver
	import i2c_bus_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input bus_event_t bus_ev,
	output logic byte_valid,
	output logic [7:0] byte_data
);

	// Bit position within the nine-clock frame
	logic [3:0] bit_cnt;
	// First seven bits of the byte
	logic [6:0] shreg;

	// Eighth bit completes the byte in this cycle
	assign byte_valid = bus_ev.scl_rise & (bit_cnt == 4'd7);
	assign byte_data = {shreg, bus_ev.sda};

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			bit_cnt <= '0;
		end
		else if (bus_ev.start)
		begin
			// Frame restarts on START or repeated START
			bit_cnt <= '0;
		end
		else if (bus_ev.scl_rise)
		begin
			// Ninth clock is the ACK slot
			if (bit_cnt == 4'd8)
			begin
				bit_cnt <= '0;
			end
			else
			begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// MSB first, ACK bit not shifted
	always_ff @(posedge Clock)
	begin
		if (bus_ev.scl_rise && (bit_cnt != 4'd8))
		begin
			shreg <= {shreg[5:0], bus_ev.sda};
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_serializer
	import i2c_bus_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input bus_event_t bus_ev,
	input ser_cmd_t cmd,
	output logic sda_low,
	output logic ser_done
);

	// Driving an ACK or a byte
	logic active;
	logic is_ack;
	// Bits still to present after the current one
	logic [2:0] bits_left;
	// Remaining data bits, MSB first
	logic [6:0] shreg;

	//////////////////////////////////////////////////
	// Output bit sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			active <= 1'b0;
			is_ack <= 1'b0;
			bits_left <= '0;
			sda_low <= 1'b0;
			ser_done <= 1'b0;
		end
		else
		begin
			ser_done <= 1'b0;
			if (bus_ev.start || bus_ev.stop)
			begin
				// Bus condition cancels any transfer
				active <= 1'b0;
				sda_low <= 1'b0;
			end
			else if (cmd.ack_go)
			begin
				// Pull low for one bit time
				active <= 1'b1;
				is_ack <= 1'b1;
				sda_low <= 1'b1;
			end
			else if (cmd.load_go)
			begin
				// Bit 7 goes out at once
				active <= 1'b1;
				is_ack <= 1'b0;
				bits_left <= 3'd7;
				sda_low <= ~cmd.data[7];
			end
			else if (active && bus_ev.scl_fall)
			begin
				if (is_ack || (bits_left == 3'd0))
				begin
					// Release line after the last bit
					active <= 1'b0;
					sda_low <= 1'b0;
					ser_done <= 1'b1;
				end
				else
				begin
					sda_low <= ~shreg[6];
					bits_left <= bits_left - 3'd1;
				end
			end
		end
	end

	// Data shifter
	always_ff @(posedge Clock)
	begin
		if (cmd.load_go)
		begin
			shreg <= cmd.data[6:0];
		end
		else if (active && !is_ack && bus_ev.scl_fall)
		begin
			shreg <= {shreg[5:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_slave_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_slave_ctrl
	import i2c_bus_pkg::*;
	import reg_access_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input bus_event_t bus_ev,
	input logic byte_valid,
	input logic [7:0] byte_data,
	input logic ser_done,
	output ser_cmd_t cmd,
	output reg_port_t reg_port,
	input logic [7:0] reg_rdata
);

	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		PTR,
		WDATA,
		RDATA,
		MACK
	} state_t;

	localparam logic [`I2C_REG_AW-1:0] LAST_REG = `I2C_REG_AW'(`I2C_NUM_REGS - 1);

	state_t state;
	// Register pointer
	logic [`I2C_REG_AW-1:0] ptr;
	logic [`I2C_REG_AW-1:0] ptr_next;
	// ACK owed on the next falling SCL
	logic ack_pend;
	// Master ACKed, next byte on falling SCL
	logic load_pend;
	// Address ACK precedes the first read byte
	logic first_load;
	logic addr_match;

	assign addr_match = (byte_data[7:1] == `I2C_DEVICE_ADDR);
	// Wrap at the end of the bank
	assign ptr_next = (ptr == LAST_REG) ? '0 : ptr + 1'b1;

	// Write each data byte at the pointer
	assign reg_port.wr = (state == WDATA) & byte_valid;
	assign reg_port.addr = ptr;
	assign reg_port.wdata = byte_data;

	//////////////////////////////////////////////////
	// Transaction FSM
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			state <= IDLE;
			ptr <= '0;
			ack_pend <= 1'b0;
			load_pend <= 1'b0;
			first_load <= 1'b0;
			cmd <= '0;
		end
		else
		begin
			// Strobes last one cycle
			cmd.ack_go <= 1'b0;
			cmd.load_go <= 1'b0;
			if (bus_ev.stop || bus_ev.start)
			begin
				// STOP ends it, START opens a new address phase
				state <= bus_ev.start ? ADDR : IDLE;
				ack_pend <= 1'b0;
				load_pend <= 1'b0;
				first_load <= 1'b0;
			end
			else
			begin
				// ACK goes out in the low phase after bit 8
				if (ack_pend && bus_ev.scl_fall)
				begin
					cmd.ack_go <= 1'b1;
					ack_pend <= 1'b0;
				end
				case (state)
					ADDR:
					begin
						if (byte_valid)
						begin
							if (addr_match)
							begin
								ack_pend <= 1'b1;
								// R/W bit picks the direction
								if (byte_data[0])
								begin
									state <= RDATA;
									first_load <= 1'b1;
								end
								else
								begin
									state <= PTR;
								end
							end
							else
							begin
								// Not ours, stay off the bus
								state <= IDLE;
							end
						end
					end
					PTR:
					begin
						if (byte_valid)
						begin
							ptr <= byte_data[`I2C_REG_AW-1:0];
							ack_pend <= 1'b1;
							state <= WDATA;
						end
					end
					WDATA:
					begin
						if (byte_valid)
						begin
							ptr <= ptr_next;
							ack_pend <= 1'b1;
						end
					end
					RDATA:
					begin
						if (ser_done)
						begin
							if (first_load)
							begin
								// Address ACK done, first byte out
								first_load <= 1'b0;
								cmd.load_go <= 1'b1;
								cmd.data <= reg_rdata;
								ptr <= ptr_next;
							end
							else
							begin
								// Byte done, master owns the ninth bit
								state <= MACK;
							end
						end
					end
					MACK:
					begin
						if (bus_ev.scl_rise)
						begin
							// Low is ACK, high is NACK
							if (!bus_ev.sda)
							begin
								load_pend <= 1'b1;
							end
							else
							begin
								state <= IDLE;
							end
						end
						else if (load_pend && bus_ev.scl_fall)
						begin
							load_pend <= 1'b0;
							cmd.load_go <= 1'b1;
							cmd.data <= reg_rdata;
							ptr <= ptr_next;
							state <= RDATA;
						end
					end
					default:
					begin
						// IDLE waits for START
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_reg_bank
	import reg_access_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	input reg_port_t reg_port,
	output logic [7:0] reg_rdata
);

	logic [7:0] regs [`I2C_NUM_REGS];

	// APB access phase and decode
	logic apb_access;
	logic apb_in_range;
	logic [`I2C_REG_AW-1:0] apb_idx;

	assign apb_access = apb_req.psel & apb_req.penable;
	assign apb_in_range = (apb_req.paddr < `I2C_APB_AW'(`I2C_NUM_REGS));
	assign apb_idx = apb_req.paddr[`I2C_REG_AW-1:0];

	//////////////////////////////////////////////////
	// APB response
	//////////////////////////////////////////////////

	// Zero wait states, out of range reads as 0
	assign apb_rsp.prdata = apb_in_range ? regs[apb_idx] : '0;
	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = apb_access & ~apb_in_range;

	// I2C side read path
	assign reg_rdata = regs[reg_port.addr];

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or posedge i2c_scl_neg_pulse)
	begin
		if (i2c_scl_neg_pulse)
		begin
			for (int i = 0; i < `I2C_NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < `I2C_NUM_REGS; i++)
			begin
				// I2C write beats APB on the same register
				if (reg_port.wr && (reg_port.addr == `I2C_REG_AW'(i)))
				begin
					regs[i] <= reg_port.wdata;
				end
				else if (apb_access && apb_req.pwrite && apb_in_range
					&& (apb_idx == `I2C_REG_AW'(i)))
				begin
					regs[i] <= apb_req.pwdata;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/i2c_slave_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_top
	import i2c_bus_pkg::*;
	import reg_access_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input logic scl,
	input logic sda,
	output logic sda_low,
	input apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	bus_event_t bus_ev;
	logic byte_valid;
	logic [7:0] byte_data;
	ser_cmd_t ser_cmd;
	logic ser_done;
	reg_port_t reg_port;
	logic [7:0] reg_rdata;

	//////////////////////////////////////////////////
	// Bus front end
	//////////////////////////////////////////////////

	i2c_line_monitor i2c_line_monitor_i (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.scl(scl),
		.sda(sda),
		.bus_ev(bus_ev)
	);

	i2c_byte_receiver i2c_byte_receiver_i (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.bus_ev(bus_ev),
		.byte_valid(byte_valid),
		.byte_data(byte_data)
	);

	// Open-drain pull-low driver
	i2c_serializer i2c_serializer_i (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.bus_ev(bus_ev),
		.cmd(ser_cmd),
		.sda_low(sda_low),
		.ser_done(ser_done)
	);

	//////////////////////////////////////////////////
	// Control and storage
	//////////////////////////////////////////////////

	i2c_slave_ctrl i2c_slave_ctrl_i (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.bus_ev(bus_ev),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.ser_done(ser_done),
		.cmd(ser_cmd),
		.reg_port(reg_port),
		.reg_rdata(reg_rdata)
	);

	i2c_reg_bank i2c_reg_bank_i (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.reg_port(reg_port),
		.reg_rdata(reg_rdata)
	);

endmodule

`default_nettype wire

//--- verif/i2c_slave_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_slave_chk
	import i2c_bus_pkg::*;
	import reg_access_pkg::*;
(
	input logic Clock,
	input logic i2c_scl_neg_pulse,
	input apb_req_t apb_req,
	input apb_rsp_t apb_rsp,
	input logic sda_low,
	input bus_event_t bus_ev
);

	// No wait states
	a_pready: assert property (@(posedge Clock) disable iff (i2c_scl_neg_pulse)
		apb_req.psel && apb_req.penable |-> apb_rsp.pready)
		else $error("pready low in an APB access cycle");

	// Error only outside the bank
	a_pslverr: assert property (@(posedge Clock) disable iff (i2c_scl_neg_pulse)
		apb_rsp.pslverr |-> (apb_req.paddr >= 8'(`I2C_NUM_REGS)))
		else $error("pslverr on an in-range address");

	// Slave only moves SDA while SCL is low
	a_sda_stable: assert property (@(posedge Clock) disable iff (i2c_scl_neg_pulse)
		bus_ev.scl_rise |-> $stable(sda_low))
		else $error("sda_low changed with an SCL rise");

	a_start_stop: assert property (@(posedge Clock) disable iff (i2c_scl_neg_pulse)
		!(bus_ev.start && bus_ev.stop))
		else $error("START and STOP pulsed together");

endmodule

bind i2c_slave_top i2c_slave_chk i2c_slave_chk_i (
	.Clock(Clock),
	.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
	.apb_req(apb_req),
	.apb_rsp(apb_rsp),
	.sda_low(sda_low),
	.bus_ev(bus_ev)
);

`default_nettype wire

//--- verif/i2c_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "i2c_settings.svh"

module i2c_slave_tb
	import reg_access_pkg::*;
();

	// SCL half period in Clock cycles
	localparam int HALF = 8;
	localparam int BIT_CYC = 2 * HALF;
	// Transaction counts
	localparam int N_APB = 24;
	localparam int N_WR = 4;
	localparam int N_RD = 4;
	// Bit times per transaction, worst case of six data bytes
	localparam int WR_BITS = 2 + 9 * 8 + 2;
	localparam int RD_BITS = 2 + 9 * 2 + 2 + 9 * 7 + 2;
	localparam int BAD_BITS = 2 + 9 * 3 + 2;
	localparam int ABORT_BITS = 2 + 9 * 2 + 2 + 9 + 3 + 2 + 1 + RD_BITS;
	localparam int I2C_CYC = BIT_CYC * (N_WR * WR_BITS + N_RD * RD_BITS + BAD_BITS + ABORT_BITS);
	// APB ops at four cycles each
	localparam int APB_OPS = 8 + N_APB + N_WR * 8 + 8 + 1 + 8;
	localparam int TOTAL_CYC = 8 + I2C_CYC + 4 * APB_OPS;
	localparam int LIMIT = TOTAL_CYC * 3 / 2;

	logic Clock;
	logic i2c_scl_neg_pulse;
	logic scl;
	// Master side of SDA, and the wired-AND line
	logic sda_m;
	logic sda_line;
	logic sda_low;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	// Mirror of the register bank
	logic [7:0] model [`I2C_NUM_REGS];
	logic [31:0] lfsr;
	int errors;
	int checks;
	int cycles;

	// Open-drain line
	assign sda_line = sda_m & ~sda_low;

	i2c_slave_top i2c_slave_top_i (
		.Clock(Clock),
		.i2c_scl_neg_pulse(i2c_scl_neg_pulse),
		.scl(scl),
		.sda(sda_line),
		.sda_low(sda_low),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial
	begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// Watchdog
	always @(posedge Clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Mismatch %s: expected %h actual %h", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// APB driver
	//////////////////////////////////////////////////

	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
		@(posedge Clock);
		apb_req.psel <= 1'b1;
		apb_req.pwrite <= 1'b1;
		apb_req.paddr <= addr;
		apb_req.pwdata <= data;
		@(posedge Clock);
		apb_req.penable <= 1'b1;
		@(negedge Clock);
		check_byte("apb write pslverr", {7'd0, addr >= 8'(`I2C_NUM_REGS)},
			{7'd0, apb_rsp.pslverr});
		@(posedge Clock);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= 1'b0;
		// Out of range writes are dropped
		if (addr < 8'(`I2C_NUM_REGS))
		begin
			model[addr[2:0]] = data;
		end
	endtask

	// Reads and compares with the model
	task automatic apb_check(input string name, input logic [7:0] addr);
		logic [7:0] exp;
		exp = (addr < 8'(`I2C_NUM_REGS)) ? model[addr[2:0]] : 8'h00;
		@(posedge Clock);
		apb_req.psel <= 1'b1;
		apb_req.pwrite <= 1'b0;
		apb_req.paddr <= addr;
		@(posedge Clock);
		apb_req.penable <= 1'b1;
		@(negedge Clock);
		check_byte(name, exp, apb_rsp.prdata);
		check_byte("apb read pslverr", {7'd0, addr >= 8'(`I2C_NUM_REGS)},
			{7'd0, apb_rsp.pslverr});
		@(posedge Clock);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic readback_all(input string name);
		for (int i = 0; i < `I2C_NUM_REGS; i++)
		begin
			apb_check(name, 8'(i));
		end
	endtask

	//////////////////////////////////////////////////
	// I2C master
	//////////////////////////////////////////////////

	// One SCL period, SDA set mid low phase, line sampled mid high phase
	task automatic clock_bit(input logic b, output logic seen);
		@(posedge Clock);
		scl <= 1'b0;
		repeat (HALF / 2 - 1) @(posedge Clock);
		@(posedge Clock);
		sda_m <= b;
		repeat (HALF / 2 - 1) @(posedge Clock);
		@(posedge Clock);
		scl <= 1'b1;
		repeat (HALF / 2 - 1) @(posedge Clock);
		@(negedge Clock);
		seen = sda_line;
		repeat (HALF / 2) @(posedge Clock);
	endtask

	// Also serves as repeated START
	task automatic start_cond();
		@(posedge Clock);
		scl <= 1'b0;
		repeat (HALF / 2) @(posedge Clock);
		sda_m <= 1'b1;
		repeat (HALF / 2) @(posedge Clock);
		scl <= 1'b1;
		repeat (HALF) @(posedge Clock);
		sda_m <= 1'b0;
		repeat (HALF) @(posedge Clock);
	endtask

	task automatic stop_cond();
		@(posedge Clock);
		scl <= 1'b0;
		repeat (HALF / 2) @(posedge Clock);
		sda_m <= 1'b0;
		repeat (HALF / 2) @(posedge Clock);
		scl <= 1'b1;
		repeat (HALF) @(posedge Clock);
		sda_m <= 1'b1;
		repeat (HALF) @(posedge Clock);
	endtask

	// Eight bits out, then the slave's ACK slot
	task automatic write_byte(input logic [7:0] data, output logic ack);
		logic seen;
		for (int i = 7; i >= 0; i--)
		begin
			clock_bit(data[i], seen);
		end
		clock_bit(1'b1, seen);
		ack = ~seen;
	endtask

	task automatic read_byte(input logic give_ack, output logic [7:0] data);
		logic seen;
		data = '0;
		for (int i = 0; i < 8; i++)
		begin
			clock_bit(1'b1, seen);
			data = {data[6:0], seen};
		end
		clock_bit(~give_ack, seen);
	endtask

	// Address plus pointer, both must be ACKed
	task automatic send_pointer(input logic [7:0] ptr);
		logic ack;
		start_cond();
		write_byte({`I2C_DEVICE_ADDR, 1'b0}, ack);
		check_byte("address ack", 8'd1, {7'd0, ack});
		write_byte(ptr, ack);
		check_byte("pointer ack", 8'd1, {7'd0, ack});
	endtask

	task automatic i2c_write_tx(input logic [7:0] ptr, input int n);
		logic ack;
		logic [7:0] d;
		logic [2:0] idx;
		idx = ptr[2:0];
		send_pointer(ptr);
		for (int i = 0; i < n; i++)
		begin
			d = 8'(take_bits(8));
			write_byte(d, ack);
			check_byte("data ack", 8'd1, {7'd0, ack});
			model[idx] = d;
			idx = idx + 3'd1;
		end
		stop_cond();
	endtask

	task automatic i2c_read_tx(input logic [7:0] ptr, input int n);
		logic ack;
		logic [7:0] d;
		logic [2:0] idx;
		idx = ptr[2:0];
		send_pointer(ptr);
		start_cond();
		write_byte({`I2C_DEVICE_ADDR, 1'b1}, ack);
		check_byte("read address ack", 8'd1, {7'd0, ack});
		// Last byte NACKed
		for (int i = 0; i < n; i++)
		begin
			read_byte(i != n - 1, d);
			check_byte("i2c read data", model[idx], d);
			idx = idx + 3'd1;
		end
		stop_cond();
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [7:0] a;
		logic [7:0] v;
		logic [7:0] p;
		int n;
		logic [6:0] bad;
		logic ack;
		logic seen;
		i2c_scl_neg_pulse = 1'b1;
		scl = 1'b1;
		sda_m = 1'b1;
		apb_req = '0;
		lfsr = 32'hac83_6ec4;
		errors = 0;
		checks = 0;
		for (int i = 0; i < `I2C_NUM_REGS; i++)
		begin
			model[i] = 8'h00;
		end
		repeat (8) @(posedge Clock);
		i2c_scl_neg_pulse <= 1'b0;
		@(negedge Clock);
		check_byte("reset sda_low", 8'd0, {7'd0, sda_low});
		readback_all("reset readback");

		// Random APB traffic, upper half of the range is invalid
		for (int i = 0; i < N_APB; i++)
		begin
			a = 8'(take_bits(4));
			if (take_bits(1) == 32'd1)
			begin
				apb_write(a, 8'(take_bits(8)));
			end
			else
			begin
				apb_check("apb random read", a);
			end
		end

		// I2C writes with wrap
		for (int i = 0; i < N_WR; i++)
		begin
			p = 8'(take_bits(8));
			n = int'(take_bits(3)) % 6 + 1;
			// First one starts at the last register and wraps
			if (i == 0)
			begin
				p = p | 8'(`I2C_NUM_REGS - 1);
				n = (n < 2) ? 2 : n;
			end
			i2c_write_tx(p, n);
			readback_all("write readback");
		end

		for (int i = 0; i < N_RD; i++)
		begin
			p = 8'(take_bits(8));
			n = int'(take_bits(3)) % 6 + 1;
			// First one reads across the end of the bank
			if (i == 0)
			begin
				p = p | 8'(`I2C_NUM_REGS - 1);
				n = (n < 2) ? 2 : n;
			end
			i2c_read_tx(p, n);
		end

		// Foreign address, nothing ACKed
		bad = 7'(take_bits(7));
		if (bad == `I2C_DEVICE_ADDR)
		begin
			bad = bad ^ 7'h01;
		end
		start_cond();
		write_byte({bad, 1'b0}, ack);
		check_byte("foreign address ack", 8'd0, {7'd0, ack});
		write_byte(8'(take_bits(8)), ack);
		check_byte("foreign pointer ack", 8'd0, {7'd0, ack});
		write_byte(8'(take_bits(8)), ack);
		check_byte("foreign data ack", 8'd0, {7'd0, ack});
		stop_cond();
		readback_all("foreign readback");

		// STOP inside a read byte
		// Bit 4 high lets the STOP through and bit 3 low exposes a live shifter
		a = 8'(take_bits(3));
		v = (8'(take_bits(8)) | 8'h10) & ~8'h08;
		apb_write(a, v);
		send_pointer(a);
		start_cond();
		write_byte({`I2C_DEVICE_ADDR, 1'b1}, ack);
		check_byte("abort address ack", 8'd1, {7'd0, ack});
		for (int i = 7; i > 4; i--)
		begin
			clock_bit(1'b1, seen);
			check_byte("abort read bit", {7'd0, v[i]}, {7'd0, seen});
		end
		stop_cond();
		// Idle SCL low phase, a cancelled slave keeps SDA free
		@(posedge Clock);
		scl <= 1'b0;
		repeat (HALF) @(posedge Clock);
		@(negedge Clock);
		check_byte("abort sda_low", 8'd0, {7'd0, sda_low});
		@(posedge Clock);
		scl <= 1'b1;
		repeat (HALF) @(posedge Clock);
		i2c_read_tx(a, 2);

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
source/i2c_bus_pkg.sv
source/reg_access_pkg.sv
source/i2c_line_monitor.sv
source/i2c_byte_receiver.sv
source/i2c_serializer.sv
source/i2c_slave_ctrl.sv
source/i2c_reg_bank.sv
source/i2c_slave_top.sv
verif/i2c_slave_chk.sv
verif/i2c_slave_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= i2c_slave_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a pass result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
